// ==== tb/ifu_vectors.txt ====
// columns: op pc latency hit, all hex
// op 1 fetch, op 2 flush, op 3 stall count (in the latency column) for the next fetch
1 00000104 2 0
1 00000104 0 1
1 00000108 1 0
// same index, other tag
1 00000504 3 0
1 00000104 2 0
1 00000108 0 1
3 00000000 5 0
1 00000108 0 1
3 00000000 3 0
1 80000200 4 0
1 80000200 0 1
2 00000000 0 0
1 00000108 1 0
1 00000108 0 1
1 00000104 0 0
1 fffffffc 2 0
1 fffffffc 0 1
// index ff conflict
1 000003fc 1 0
1 fffffffc 0 0
2 00000000 0 0
2 00000000 0 0
1 000003fc 0 0
3 00000000 2 0
1 000003fc 0 1

// ==== compile.f ====
+incdir+src
src/ifu_pkg.sv
src/ifu_icache.sv
src/ifu_bus_reader.sv
src/ifu_fetch_ctrl.sv
src/ifu_top.sv
tb/ifu_assertions.sv
tb/ifu_tb.sv

// ==== tb/ifu_tb.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_tb;

  localparam int          MAX_VEC = 64;
  localparam logic [31:0] MEM_KEY = 32'h5A5A_0013;

  logic                   clk;
  logic                   rst;
  logic                   req_i;
  logic [`IFU_ADDR_W-1:0] pc_i;
  logic                   flush_i;
  logic                   ready_o;
  logic                   valid_o;
  logic [`IFU_DATA_W-1:0] inst_o;
  logic [`IFU_ADDR_W-1:0] pc_o;
  logic                   next_ready_i;
  logic [`IFU_ADDR_W-1:0] araddr_o;
  logic                   arvalid_o;
  logic [`IFU_DATA_W-1:0] rdata_i;
  logic                   rvalid_i;

  // four words per vector: op, pc, latency or stall count, expected hit
  logic [31:0] vec_mem [4*MAX_VEC];
  int          vec_count;
  int          max_lat;
  int          max_stall;
  int          test_errs;
  int          pass_count;
  int          fail_count;
  int          pending_stall;
  bit          loaded;

  ifu_top ifu_top_i (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .pc_i         (pc_i),
    .flush_i      (flush_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .next_ready_i (next_ready_i),
    .araddr_o     (araddr_o),
    .arvalid_o    (arvalid_o),
    .rdata_i      (rdata_i),
    .rvalid_i     (rvalid_i)
  );

  always #4 clk = ~clk;

  // memory contents at any address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ MEM_KEY;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_cond(input bit ok, input string msg);
    assert (ok)
    else
    begin
      $display("Check failed: %s", msg);
      test_errs++;
    end
  endtask

  // one fetch, with the memory model answering a miss after lat cycles
  task automatic run_fetch(input logic [31:0] pc, input int lat, input bit exp_hit,
                           input int stall);
    int          k;
    int          ar_k;
    int          ar_wait;
    bit          ar_seen;
    k       = 0;
    ar_k    = -1;
    ar_wait = 0;
    ar_seen = 1'b0;
    check_cond(ready_o, "request issued while ready_o was low");
    req_i = 1'b1;
    pc_i  = pc;
    @(negedge clk);
    req_i = 1'b0;
    while (!valid_o)
    begin
      rvalid_i = 1'b0;
      check_cond(!ready_o, "ready_o high while a fetch is in flight");
      if (arvalid_o)
      begin
        if (!ar_seen)
        begin
          ar_seen = 1'b1;
          ar_k    = k;
        end
        check_value("araddr_o", araddr_o, pc);
        if (ar_wait == lat)
        begin
          rvalid_i = 1'b1;
          rdata_i  = mem_word(araddr_o);
        end
        ar_wait++;
      end
      @(negedge clk);
      k++;
    end
    rvalid_i = 1'b0;
    check_value("arvalid_o", ar_seen, !exp_hit);
    if (exp_hit)
      check_cond(k == 2, $sformatf("hit answered after %0d cycles instead of 2", k));
    else
      check_cond(ar_k == 2 && k == 3 + lat,
                 $sformatf("miss timing wrong, read after %0d and answer after %0d cycles",
                           ar_k, k));
    check_value("inst_o", inst_o, mem_word(pc));
    check_value("pc_o", pc_o, pc);
    repeat (stall)
    begin
      @(negedge clk);
      check_cond(valid_o, "valid_o dropped under back-pressure");
      check_cond(!ready_o, "ready_o high under back-pressure");
      check_value("inst_o", inst_o, mem_word(pc));
      check_value("pc_o", pc_o, pc);
    end
    next_ready_i = 1'b1;
    @(negedge clk);
    next_ready_i = 1'b0;
    check_cond(!valid_o && ready_o, "no return to idle after consumption");
  endtask

  task automatic run_flush();
    check_cond(ready_o, "flush issued while ready_o was low");
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
  endtask

  // limit derived from the vector count and the longest fetch
  initial
  begin
    wait (loaded);
    repeat (vec_count * (max_lat + max_stall + 10) + 20) @(posedge clk);
    $display("Timeout: the vectors did not complete in time");
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    int op;
    int extra;
    int stall;
    int assert_base;
    clk           = 1'b0;
    rst           = 1'b1;
    req_i         = 1'b0;
    pc_i          = '0;
    flush_i       = 1'b0;
    next_ready_i  = 1'b0;
    rdata_i       = '0;
    rvalid_i      = 1'b0;
    pass_count    = 0;
    fail_count    = 0;
    pending_stall = 0;
    loaded        = 1'b0;
    void'($urandom(84));
    for (int i = 0; i < 4*MAX_VEC; i++)
      vec_mem[i] = '0;
    $readmemh("tb/ifu_vectors.txt", vec_mem);
    vec_count = 0;
    max_lat   = 0;
    max_stall = 0;
    while (vec_count < MAX_VEC && vec_mem[4*vec_count] != 0)
    begin
      if (vec_mem[4*vec_count] == 1 && vec_mem[4*vec_count+2] > max_lat)
        max_lat = vec_mem[4*vec_count+2];
      if (vec_mem[4*vec_count] == 3 && vec_mem[4*vec_count+2] > max_stall)
        max_stall = vec_mem[4*vec_count+2];
      vec_count++;
    end
    // room for the random extras
    max_lat   += 3;
    max_stall += 1;
    loaded     = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int v = 0; v < vec_count; v++)
    begin
      test_errs   = 0;
      assert_base = ifu_top_i.ifu_assertions_i.fail_cnt;
      op          = vec_mem[4*v];
      case (op)
        1:
        begin
          extra = $urandom % 4;
          stall = pending_stall + ($urandom % 2);
          run_fetch(vec_mem[4*v+1], vec_mem[4*v+2] + extra, vec_mem[4*v+3][0], stall);
          pending_stall = 0;
        end
        2:       run_flush();
        3:       pending_stall = vec_mem[4*v+2];
        default: check_cond(1'b0, "unknown vector operation");
      endcase
      if (ifu_top_i.ifu_assertions_i.fail_cnt != assert_base)
      begin
        $display("Protocol assertion failed during this vector");
        test_errs++;
      end
      if (test_errs == 0)
      begin
        pass_count++;
        $display("vector %0d op %0d pc %h: ok", v, op, vec_mem[4*v+1]);
      end
      else
      begin
        fail_count++;
        $display("vector %0d op %0d pc %h: FAILED with %0d errors", v, op,
                 vec_mem[4*v+1], test_errs);
      end
    end
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== tb/ifu_assertions.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_assertions
  import ifu_pkg::*;
(
  input logic                   clk,
  input logic                   rst,
  input logic                   ready_i,
  input logic                   valid_i,
  input logic [`IFU_DATA_W-1:0] inst_i,
  input logic                   next_ready_i,
  input logic [`IFU_ADDR_W-1:0] araddr_i,
  input logic                   arvalid_i,
  input logic                   rvalid_i,
  input fetch_state_e           state_i
);

  // number of assertion failures so far
  int fail_cnt = 0;

  // read request held until the response pulse
  a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
    (arvalid_i && !rvalid_i) |=> (arvalid_i && $stable(araddr_i)))
  else
  begin
    $error("araddr_o or arvalid_o changed while a read was outstanding");
    fail_cnt++;
  end

  // instruction held under back-pressure
  a_inst_stable: assert property (@(posedge clk) disable iff (rst)
    (valid_i && !next_ready_i) |=> (valid_i && $stable(inst_i)))
  else
  begin
    $error("inst_o or valid_o changed before consumption");
    fail_cnt++;
  end

  a_ready_valid_excl: assert property (@(posedge clk) disable iff (rst)
    !(ready_i && valid_i))
  else
  begin
    $error("ready_o and valid_o high together");
    fail_cnt++;
  end

  // MISS always has its bus read outstanding
  a_miss_has_read: assert property (@(posedge clk) disable iff (rst)
    (state_i == MISS) |-> arvalid_i)
  else
  begin
    $error("controller waits in MISS without a bus read");
    fail_cnt++;
  end

endmodule

bind ifu_top ifu_assertions ifu_assertions_i (
  .clk          (clk),
  .rst          (rst),
  .ready_i      (ready_o),
  .valid_i      (valid_o),
  .inst_i       (inst_o),
  .next_ready_i (next_ready_i),
  .araddr_i     (araddr_o),
  .arvalid_i    (arvalid_o),
  .rvalid_i     (rvalid_i),
  .state_i      (u_ctrl.state)
);

// ==== src/ifu_top.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_top
  import ifu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_i,
  input  logic [`IFU_ADDR_W-1:0] pc_i,
  input  logic                   flush_i,
  output logic                   ready_o,
  output logic                   valid_o,
  output logic [`IFU_DATA_W-1:0] inst_o,
  output logic [`IFU_ADDR_W-1:0] pc_o,
  input  logic                   next_ready_i,
  output logic [`IFU_ADDR_W-1:0] araddr_o,
  output logic                   arvalid_o,
  input  logic [`IFU_DATA_W-1:0] rdata_i,
  input  logic                   rvalid_i
);

  // controller to cache
  logic                   lookup;
  fetch_addr_t            fetch_addr;
  logic                   flush;
  logic                   fill;
  logic [`IFU_DATA_W-1:0] fill_data;
  logic                   hit;
  logic [`IFU_DATA_W-1:0] cache_data;

  // controller to bus reader
  logic                   start;
  logic                   done;
  logic [`IFU_DATA_W-1:0] bus_data;

  ifu_fetch_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .pc_i         (pc_i),
    .flush_i      (flush_i),
    .next_ready_i (next_ready_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .lookup_o     (lookup),
    .addr_o       (fetch_addr),
    .flush_o      (flush),
    .hit_i        (hit),
    .cache_data_i (cache_data),
    .start_o      (start),
    .done_i       (done),
    .bus_data_i   (bus_data),
    .fill_o       (fill),
    .fill_data_o  (fill_data)
  );

  ifu_icache u_icache (
    .clk         (clk),
    .rst         (rst),
    .lookup_i    (lookup),
    .addr_i      (fetch_addr),
    .fill_i      (fill),
    .fill_data_i (fill_data),
    .flush_i     (flush),
    .hit_o       (hit),
    .data_o      (cache_data)
  );

  ifu_bus_reader u_bus_reader (
    .clk       (clk),
    .rst       (rst),
    .start_i   (start),
    .addr_i    (fetch_addr),
    .araddr_o  (araddr_o),
    .arvalid_o (arvalid_o),
    .rdata_i   (rdata_i),
    .rvalid_i  (rvalid_i),
    .done_o    (done),
    .data_o    (bus_data)
  );

endmodule

// ==== src/ifu_fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_fetch_ctrl
  import ifu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // core request side
  input  logic                   req_i,
  input  logic [`IFU_ADDR_W-1:0] pc_i,
  input  logic                   flush_i,
  input  logic                   next_ready_i,
  output logic                   ready_o,
  output logic                   valid_o,
  output logic [`IFU_DATA_W-1:0] inst_o,
  output logic [`IFU_ADDR_W-1:0] pc_o,
  // cache
  output logic                   lookup_o,
  output fetch_addr_t            addr_o,
  output logic                   flush_o,
  input  logic                   hit_i,
  input  logic [`IFU_DATA_W-1:0] cache_data_i,
  // bus reader
  output logic                   start_o,
  input  logic                   done_i,
  input  logic [`IFU_DATA_W-1:0] bus_data_i,
  // cache fill
  output logic                   fill_o,
  output logic [`IFU_DATA_W-1:0] fill_data_o
);

  fetch_state_e           state;
  logic                   lookup_q;
  fetch_addr_t            addr_q;
  logic [`IFU_DATA_W-1:0] inst_q;

  logic accept;
  logic eval;
  logic take_hit;
  logic take_bus;
  logic miss;

  assign ready_o = (state == IDLE);
  assign valid_o = (state == HOLD);
  assign accept  = ready_o && req_i;

  // first LOOKUP cycle is the cache read, second one has the result
  assign eval     = (state == LOOKUP) && !lookup_q;
  assign take_hit = eval && hit_i;
  assign miss     = eval && !hit_i;
  assign take_bus = (state == MISS) && done_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= IDLE;
      lookup_q <= 1'b0;
    end
    else
    begin
      lookup_q <= accept;
      case (state)
        IDLE:
        begin
          if (accept)
          begin
            state <= LOOKUP;
          end
        end
        LOOKUP:
        begin
          if (take_hit)
          begin
            state <= HOLD;
          end
          else if (miss)
          begin
            state <= MISS;
          end
        end
        MISS:
        begin
          if (take_bus)
          begin
            state <= HOLD;
          end
        end
        HOLD:
        begin
          // back to IDLE once decode takes it
          if (next_ready_i)
          begin
            state <= IDLE;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // pc and instruction payload
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q.raw <= pc_i;
    end
    if (take_hit)
    begin
      inst_q <= cache_data_i;
    end
    else if (take_bus)
    begin
      inst_q <= bus_data_i;
    end
  end

  assign inst_o = inst_q;
  assign pc_o   = addr_q.raw;

  assign lookup_o = lookup_q;
  assign addr_o   = addr_q;

  // flush only when idle with no request pending
  assign flush_o = ready_o && flush_i && !req_i;

  assign start_o = miss;

  // the fill writes the same word that goes to HOLD
  assign fill_o      = take_bus;
  assign fill_data_o = bus_data_i;

endmodule

// ==== src/ifu_bus_reader.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_bus_reader
  import ifu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  fetch_addr_t            addr_i,
  output logic [`IFU_ADDR_W-1:0] araddr_o,
  output logic                   arvalid_o,
  input  logic [`IFU_DATA_W-1:0] rdata_i,
  input  logic                   rvalid_i,
  output logic                   done_o,
  output logic [`IFU_DATA_W-1:0] data_o
);

  logic                   arvalid_q;
  logic [`IFU_ADDR_W-1:0] araddr_q;
  logic                   resp_ok;

  // response only counts while a read is outstanding
  assign resp_ok = arvalid_q && rvalid_i;

  // request flag
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      arvalid_q <= 1'b0;
    end
    else
    begin
      if (start_i)
      begin
        arvalid_q <= 1'b1;
      end
      else if (resp_ok)
      begin
        arvalid_q <= 1'b0;
      end
    end
  end

  // request address, held until the response pulse
  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      araddr_q <= addr_i.raw;
    end
  end

  assign arvalid_o = arvalid_q;
  assign araddr_o  = araddr_q;

  // returned word goes straight through with done
  assign done_o = resp_ok;
  assign data_o = rdata_i;

endmodule

// ==== src/ifu_icache.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_icache
  import ifu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   lookup_i,
  input  fetch_addr_t            addr_i,
  input  logic                   fill_i,
  input  logic [`IFU_DATA_W-1:0] fill_data_i,
  input  logic                   flush_i,
  output logic                   hit_o,
  output logic [`IFU_DATA_W-1:0] data_o
);

  // storage arrays
  logic [`IFU_DATA_W-1:0] data_mem [`IFU_LINES];
  logic [`IFU_TAG_W-1:0]  tag_mem  [`IFU_LINES];
  logic [`IFU_LINES-1:0]  valid_bits;

  // address latched on lookup, reused by the fill
  logic [`IFU_IDX_W-1:0]  idx_q;
  logic [`IFU_TAG_W-1:0]  tag_q;

  // registered array read
  logic [`IFU_TAG_W-1:0]  tag_rd;
  logic [`IFU_DATA_W-1:0] data_rd;
  logic                   valid_rd;

  // valid bits and the registered valid read
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_bits <= '0;
      valid_rd   <= 1'b0;
    end
    else
    begin
      if (flush_i)
      begin
        valid_bits <= '0;
      end
      else if (fill_i)
      begin
        valid_bits[idx_q] <= 1'b1;
      end
      if (lookup_i)
      begin
        valid_rd <= valid_bits[addr_i.dec.idx];
      end
    end
  end

  // lookup side of tag and data arrays
  always_ff @(posedge clk)
  begin
    if (lookup_i)
    begin
      idx_q   <= addr_i.dec.idx;
      tag_q   <= addr_i.dec.tag;
      tag_rd  <= tag_mem[addr_i.dec.idx];
      data_rd <= data_mem[addr_i.dec.idx];
    end
  end

  // fill at the latched index
  always_ff @(posedge clk)
  begin
    if (fill_i)
    begin
      data_mem[idx_q] <= fill_data_i;
      tag_mem[idx_q]  <= tag_q;
    end
  end

  // hit once the stored tag matches the requested one
  assign hit_o  = valid_rd && (tag_rd == tag_q);
  assign data_o = data_rd;

endmodule

// ==== src/ifu_pkg.sv ====
`include "ifu_params.svh"

package ifu_pkg;

  // one pc word, seen as a bus address or as the cache decode
  typedef union packed {
    logic [`IFU_ADDR_W-1:0] raw;
    struct packed {
      logic [`IFU_TAG_W-1:0] tag;
      logic [`IFU_IDX_W-1:0] idx;
      logic [`IFU_OFF_W-1:0] off;
    } dec;
  } fetch_addr_t;

  // controller states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOOKUP = 2'd1,
    MISS   = 2'd2,
    HOLD   = 2'd3
  } fetch_state_e;

endpackage

// ==== src/ifu_params.svh ====
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// fetch address and bus word
`define IFU_ADDR_W 32
`define IFU_DATA_W 32

// direct-mapped, one word per line
`define IFU_LINES 256

// index from pc[9:2], tag from pc[31:10]
`define IFU_IDX_W 8
`define IFU_TAG_W 22

// byte offset inside a word
`define IFU_OFF_W 2

`endif
